/* csr_access_decode.sv */
`timescale 1ns/1ps

module csr_access_decode #(
    parameter csr_pkg::data_word_t HART_ID = '0
) (
    input  csr_pkg::csr_addr_t  csr_address_i,
    input  logic                csr_write_access_i,
    input  logic                csr_read_access_i,
    input  csr_pkg::priv_e      privilege_i,
    input  csr_pkg::data_word_t mstatus_i,
    input  csr_pkg::data_word_t mtvec_i,
    input  csr_pkg::data_word_t mepc_i,
    input  csr_pkg::data_word_t mcause_i,
    input  csr_pkg::data_word_t mscratch_i,
    input  csr_pkg::data_word_t handler_pc_i,
    input  csr_pkg::counter_t   mcycle_i,
    input  csr_pkg::counter_t   minstret_i,
    input  logic [2:0]          mcountinhibit_i,
    input  logic [2:0]          mcounteren_i,
    output csr_pkg::csr_wen_t   push_wen_o,
    output logic                push_o,
    output csr_pkg::data_word_t csr_data_read_o,
    output logic                illegal_csr_access_o
);

    logic no_csr, cnt_denied, user_mode;
    logic ro_write, machine_denied, illegal;
    logic cnt_sel;

    assign user_mode = (privilege_i == csr_pkg::PRIV_USER);

    // ============================================================
    // Address map
    // ============================================================

    always_comb begin
        push_wen_o      = '0;
        csr_data_read_o = '0;
        no_csr          = 1'b0;
        cnt_sel         = 1'b0;
        cnt_denied      = 1'b0;

        case (csr_address_i)
            // Read-only identification
            csr_pkg::ADDR_MVENDORID: csr_data_read_o = csr_pkg::MVENDORID_VALUE;
            csr_pkg::ADDR_MARCHID:   csr_data_read_o = csr_pkg::MARCHID_VALUE;
            csr_pkg::ADDR_MIMPID:    csr_data_read_o = csr_pkg::MIMPID_VALUE;
            csr_pkg::ADDR_MHARTID:   csr_data_read_o = HART_ID;

            // Machine read-write
            csr_pkg::ADDR_MSTATUS: begin
                csr_data_read_o = mstatus_i;
                push_wen_o[csr_pkg::WEN_MSTATUS] = 1'b1;
            end
            csr_pkg::ADDR_MTVEC: begin
                csr_data_read_o = mtvec_i;
                push_wen_o[csr_pkg::WEN_MTVEC] = 1'b1;
            end
            csr_pkg::ADDR_MCOUNTEREN: begin
                csr_data_read_o = {29'b0, mcounteren_i};
                push_wen_o[csr_pkg::WEN_MCOUNTEREN] = 1'b1;
            end
            csr_pkg::ADDR_MCOUNTINHIBIT: begin
                csr_data_read_o = {29'b0, mcountinhibit_i};
                push_wen_o[csr_pkg::WEN_MCOUNTINHIBIT] = 1'b1;
            end
            csr_pkg::ADDR_MSCRATCH: begin
                csr_data_read_o = mscratch_i;
                push_wen_o[csr_pkg::WEN_MSCRATCH] = 1'b1;
            end
            csr_pkg::ADDR_MEPC: begin
                csr_data_read_o = mepc_i;
                push_wen_o[csr_pkg::WEN_MEPC] = 1'b1;
            end
            csr_pkg::ADDR_MCAUSE: begin
                csr_data_read_o = mcause_i;
                push_wen_o[csr_pkg::WEN_MCAUSE] = 1'b1;
            end

            // User counters, gated by mcounteren in user mode
            csr_pkg::ADDR_CYCLE, csr_pkg::ADDR_CYCLEH: begin
                cnt_sel         = 1'b1;
                cnt_denied      = !mcounteren_i[csr_pkg::CNT_CYCLE_BIT];
                csr_data_read_o = csr_address_i[7] ? mcycle_i[63:32] : mcycle_i[31:0];
            end
            csr_pkg::ADDR_INSTRET, csr_pkg::ADDR_INSTRETH: begin
                cnt_sel         = 1'b1;
                cnt_denied      = !mcounteren_i[csr_pkg::CNT_INSTRET_BIT];
                csr_data_read_o = csr_address_i[7] ? minstret_i[63:32] : minstret_i[31:0];
            end

            default: no_csr = 1'b1;
        endcase
    end

    // Top two address bits set mark a read-only CSR
    assign ro_write = csr_write_access_i & (csr_address_i[11:10] == 2'b11);

    // Bits 9:8 encode the lowest privilege allowed
    assign machine_denied = user_mode & (csr_address_i[9:8] == 2'b11);

    assign illegal = no_csr | ro_write | machine_denied | (user_mode & cnt_sel & cnt_denied);

    assign illegal_csr_access_o = illegal & (csr_write_access_i | csr_read_access_i);
    assign push_o               = csr_write_access_i & !illegal;

endmodule : csr_access_decode

/* csr_counters.sv */
`timescale 1ns/1ps

module csr_counters (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  csr_pkg::csr_wen_t   commit_wen_i,
    input  csr_pkg::data_word_t commit_data_i,
    input  logic                instruction_retired_i,
    output csr_pkg::counter_t   mcycle_o,
    output csr_pkg::counter_t   minstret_o,
    output logic [2:0]          mcountinhibit_o,
    output logic [2:0]          mcounteren_o
);

    csr_pkg::counter_t mcycle_q, minstret_q;
    logic [2:0]        inhibit_q, counteren_q;
    logic [2:0]        ctrl_wdata;

    // Only cycle and instret bits exist
    assign ctrl_wdata = {commit_data_i[csr_pkg::CNT_INSTRET_BIT], 1'b0,
                         commit_data_i[csr_pkg::CNT_CYCLE_BIT]};

    // ============================================================
    // Counter control registers
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            inhibit_q   <= '0;
            counteren_q <= '0;
        end else begin
            if (commit_wen_i[csr_pkg::WEN_MCOUNTINHIBIT]) begin
                inhibit_q <= ctrl_wdata;
            end
            if (commit_wen_i[csr_pkg::WEN_MCOUNTEREN]) begin
                counteren_q <= ctrl_wdata;
            end
        end
    end

    // Free running unless inhibited
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            if (!inhibit_q[csr_pkg::CNT_CYCLE_BIT]) begin
                mcycle_q <= mcycle_q + 1'b1;
            end
            if (instruction_retired_i && !inhibit_q[csr_pkg::CNT_INSTRET_BIT]) begin
                minstret_q <= minstret_q + 1'b1;
            end
        end
    end

    assign mcycle_o        = mcycle_q;
    assign minstret_o      = minstret_q;
    assign mcountinhibit_o = inhibit_q;
    assign mcounteren_o    = counteren_q;

endmodule : csr_counters

/* csr_patterns.hex */
// Columns: opcode address data expected (hex). Opcodes: 0 idle, 1 write, 2 write random,
// 3 validate, 4 flush, 5 read (data 0 exact 1 random 2 mark 3 delta 4 hartid), 6 illegal
// (data 0 read 1 write), 7 exception, 8 interrupt, 9 mret, A retire, B full, C handler,
// D user mode, F end
2 340 0 0
5 340 0 0
3 000 0 0
5 340 1 0
1 340 11111111 0
1 340 22222222 0
4 000 0 0
3 000 0 0
5 340 1 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
1 340 AAAAAAAA 0
B 000 0 1
4 000 0 0
B 000 0 0
// Trap state, direct then vectored mtvec
1 300 00000008 0
3 000 0 0
5 300 0 00000008
1 305 00001000 0
3 000 0 0
5 305 0 00001000
C 000 0 00001000
7 000 2 0
5 341 1 0
5 342 0 00000002
5 300 0 00001880
C 000 0 00001000
1 305 00001001 0
3 000 0 0
8 000 7 0
C 000 0 0000101C
5 342 0 80000007
5 341 1 0
5 300 0 00001800
// Privilege and access rules
1 300 0 0
3 000 0 0
9 000 0 0
D 000 0 1
6 340 0 1
6 C00 0 1
6 C00 1 1
7 000 8 0
D 000 0 0
5 342 0 00000008
1 306 1 0
3 000 0 0
5 306 0 00000001
9 000 0 0
D 000 0 1
6 C00 0 0
6 C02 0 1
6 305 0 1
7 000 3 0
D 000 0 0
6 F11 1 1
6 7C0 0 1
// Counters
5 C00 2 0
0 000 9 0
5 C00 3 0000000A
A 000 3 0
5 C02 0 00000003
1 320 4 0
3 000 0 0
5 320 0 00000004
A 000 5 0
5 C02 0 00000003
5 C82 0 0
// Identification
5 F11 0 00000A5E
5 F12 0 00000019
5 F13 0 00010000
5 F14 4 0
F 000 0 0

/* csr_pkg.sv */
package csr_pkg;

    // ============================================================
    // Typed widths
    // ============================================================

    typedef logic [31:0] data_word_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [63:0] counter_t;
    typedef logic [7:0]  trap_cause_t;

    // One bit per writable register, one-hot when a write is pending
    typedef logic [6:0]  csr_wen_t;

    // Standard RISC-V encoding of the two supported modes
    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Commit-enable bit positions
    localparam int WEN_MSTATUS       = 0;
    localparam int WEN_MTVEC         = 1;
    localparam int WEN_MSCRATCH      = 2;
    localparam int WEN_MEPC          = 3;
    localparam int WEN_MCAUSE        = 4;
    localparam int WEN_MCOUNTINHIBIT = 5;
    localparam int WEN_MCOUNTEREN    = 6;

    // ============================================================
    // CSR addresses
    // ============================================================

    localparam csr_addr_t ADDR_MVENDORID     = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID       = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID        = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID       = 12'hF14;
    localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
    localparam csr_addr_t ADDR_MTVEC         = 12'h305;
    localparam csr_addr_t ADDR_MCOUNTEREN    = 12'h306;
    localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
    localparam csr_addr_t ADDR_MEPC          = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
    localparam csr_addr_t ADDR_CYCLE         = 12'hC00;
    localparam csr_addr_t ADDR_INSTRET       = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH        = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH      = 12'hC82;

    // Identification constants
    localparam data_word_t MVENDORID_VALUE = 32'h0000_0A5E;
    localparam data_word_t MARCHID_VALUE   = 32'h0000_0019;
    localparam data_word_t MIMPID_VALUE    = 32'h0001_0000;

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    // Bits of mcountinhibit and mcounteren, bit 1 is hardwired to zero
    localparam int CNT_CYCLE_BIT   = 0;
    localparam int CNT_INSTRET_BIT = 2;

endpackage : csr_pkg

/* csr_trap_regs.sv */
`timescale 1ns/1ps

module csr_trap_regs (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  csr_pkg::csr_wen_t    commit_wen_i,
    input  csr_pkg::data_word_t  commit_data_i,
    input  logic                 interrupt_request_i,
    input  logic                 exception_i,
    input  logic                 machine_return_instr_i,
    input  csr_pkg::trap_cause_t interrupt_vector_i,
    input  logic [4:0]           exception_vector_i,
    input  csr_pkg::data_word_t  trap_instruction_pc_i,
    output csr_pkg::priv_e       privilege_o,
    output csr_pkg::data_word_t  mstatus_o,
    output csr_pkg::data_word_t  mtvec_o,
    output csr_pkg::data_word_t  mepc_o,
    output csr_pkg::data_word_t  mcause_o,
    output csr_pkg::data_word_t  mscratch_o,
    output csr_pkg::data_word_t  handler_pc_o,
    output logic                 glb_int_enabled_o
);

    csr_pkg::priv_e      priv_q, mpp_q, mpp_wdata;
    logic                mie_q, mpie_q;
    logic                trap;
    csr_pkg::data_word_t mtvec_q, mepc_q, mcause_q, mscratch_q;
    csr_pkg::data_word_t handler_pc_q, tvec_base;

    assign trap = interrupt_request_i | exception_i;

    // MPP only holds legal modes, anything but machine maps to user
    assign mpp_wdata = (commit_data_i[csr_pkg::MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                       csr_pkg::PRIV_MACHINE : csr_pkg::PRIV_USER;

    // ============================================================
    // Privilege and mstatus
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            priv_q <= csr_pkg::PRIV_MACHINE;
            mpp_q  <= csr_pkg::PRIV_USER;
            mie_q  <= 1'b0;
            mpie_q <= 1'b0;
        end else if (trap) begin
            // Enter machine mode with interrupts off
            priv_q <= csr_pkg::PRIV_MACHINE;
            mpp_q  <= priv_q;
            mpie_q <= mie_q;
            mie_q  <= 1'b0;
        end else if (machine_return_instr_i) begin
            priv_q <= mpp_q;
            mpp_q  <= csr_pkg::PRIV_USER;
            mie_q  <= mpie_q;
            mpie_q <= 1'b1;
        end else if (commit_wen_i[csr_pkg::WEN_MSTATUS]) begin
            mie_q  <= commit_data_i[csr_pkg::MSTATUS_MIE_BIT];
            mpie_q <= commit_data_i[csr_pkg::MSTATUS_MPIE_BIT];
            mpp_q  <= mpp_wdata;
        end
    end

    // ============================================================
    // mepc, mcause, mtvec, mscratch
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else begin
            if (trap) begin
                mepc_q <= trap_instruction_pc_i;
            end else if (commit_wen_i[csr_pkg::WEN_MEPC]) begin
                mepc_q <= {commit_data_i[31:1], 1'b0};
            end

            // Interrupt wins over a simultaneous exception
            if (interrupt_request_i) begin
                mcause_q <= {1'b1, 23'b0, interrupt_vector_i};
            end else if (exception_i) begin
                mcause_q <= {24'b0, csr_pkg::trap_cause_t'(exception_vector_i)};
            end else if (commit_wen_i[csr_pkg::WEN_MCAUSE]) begin
                mcause_q <= commit_data_i;
            end

            if (commit_wen_i[csr_pkg::WEN_MTVEC]) begin
                mtvec_q <= commit_data_i;
            end
            if (commit_wen_i[csr_pkg::WEN_MSCRATCH]) begin
                mscratch_q <= commit_data_i;
            end
        end
    end

    // Handler PC, mode 1 is vectored and offsets interrupts only
    assign tvec_base = {mtvec_q[31:2], 2'b00};

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            handler_pc_q <= '0;
        end else if (mtvec_q[1:0] == 2'b01 && interrupt_request_i) begin
            handler_pc_q <= tvec_base + {22'b0, interrupt_vector_i, 2'b00};
        end else begin
            handler_pc_q <= tvec_base;
        end
    end

    assign privilege_o       = priv_q;
    assign mstatus_o         = {19'b0, mpp_q, 3'b0, mpie_q, 3'b0, mie_q, 3'b0};
    assign mtvec_o           = mtvec_q;
    assign mepc_o            = mepc_q;
    assign mcause_o          = mcause_q;
    assign mscratch_o        = mscratch_q;
    assign handler_pc_o      = handler_pc_q;
    assign glb_int_enabled_o = mie_q;

    // Trap PCs from the core are always halfword aligned
    a_mepc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !mepc_q[0]);

endmodule : csr_trap_regs

/* csr_unit_top.sv */
`timescale 1ns/1ps

module csr_unit_top #(
    parameter int unsigned         BUFFER_DEPTH = 8,
    parameter csr_pkg::data_word_t HART_ID      = '0
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 csr_write_access_i,
    input  logic                 csr_read_access_i,
    input  csr_pkg::csr_addr_t   csr_address_i,
    input  csr_pkg::data_word_t  csr_data_write_i,
    input  logic                 csr_write_validate_i,
    input  logic                 flush_i,
    input  logic                 instruction_retired_i,
    input  logic                 interrupt_request_i,
    input  logic                 exception_i,
    input  csr_pkg::trap_cause_t interrupt_vector_i,
    input  logic [4:0]           exception_vector_i,
    input  csr_pkg::data_word_t  trap_instruction_pc_i,
    input  logic                 machine_return_instr_i,
    output csr_pkg::data_word_t  csr_data_read_o,
    output logic                 illegal_csr_access_o,
    output logic                 buffer_full_o,
    output csr_pkg::data_word_t  handler_pc_o,
    output logic                 glb_int_enabled_o,
    output logic                 current_privilege_o
);

    csr_pkg::csr_wen_t   push_wen, commit_wen;
    csr_pkg::data_word_t commit_data;
    logic                push;
    csr_pkg::priv_e      privilege;
    csr_pkg::data_word_t mstatus, mtvec, mepc, mcause, mscratch;
    csr_pkg::counter_t   mcycle, minstret;
    logic [2:0]          mcountinhibit, mcounteren;

    // High while running in user mode
    assign current_privilege_o = (privilege == csr_pkg::PRIV_USER);

    csr_access_decode #(.HART_ID(HART_ID)) u_decode (
        .csr_address_i(csr_address_i), .csr_write_access_i(csr_write_access_i),
        .csr_read_access_i(csr_read_access_i), .privilege_i(privilege),
        .mstatus_i(mstatus), .mtvec_i(mtvec), .mepc_i(mepc), .mcause_i(mcause),
        .mscratch_i(mscratch), .handler_pc_i(handler_pc_o),
        .mcycle_i(mcycle), .minstret_i(minstret),
        .mcountinhibit_i(mcountinhibit), .mcounteren_i(mcounteren),
        .push_wen_o(push_wen), .push_o(push),
        .csr_data_read_o(csr_data_read_o), .illegal_csr_access_o(illegal_csr_access_o)
    );

    csr_write_buffer #(.BUFFER_DEPTH(BUFFER_DEPTH)) u_buffer (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .flush_i(flush_i),
        .push_i(push), .push_wen_i(push_wen), .push_data_i(csr_data_write_i),
        .validate_i(csr_write_validate_i), .full_o(buffer_full_o),
        .commit_wen_o(commit_wen), .commit_data_o(commit_data)
    );

    csr_trap_regs u_trap (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .commit_wen_i(commit_wen), .commit_data_i(commit_data),
        .interrupt_request_i(interrupt_request_i), .exception_i(exception_i),
        .machine_return_instr_i(machine_return_instr_i),
        .interrupt_vector_i(interrupt_vector_i), .exception_vector_i(exception_vector_i),
        .trap_instruction_pc_i(trap_instruction_pc_i),
        .privilege_o(privilege), .mstatus_o(mstatus), .mtvec_o(mtvec), .mepc_o(mepc),
        .mcause_o(mcause), .mscratch_o(mscratch), .handler_pc_o(handler_pc_o),
        .glb_int_enabled_o(glb_int_enabled_o)
    );

    csr_counters u_counters (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .commit_wen_i(commit_wen), .commit_data_i(commit_data),
        .instruction_retired_i(instruction_retired_i),
        .mcycle_o(mcycle), .minstret_o(minstret),
        .mcountinhibit_o(mcountinhibit), .mcounteren_o(mcounteren)
    );

endmodule : csr_unit_top

/* csr_write_buffer.sv */
`timescale 1ns/1ps

module csr_write_buffer #(
    parameter int unsigned BUFFER_DEPTH = 8
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                flush_i,
    input  logic                push_i,
    input  csr_pkg::csr_wen_t   push_wen_i,
    input  csr_pkg::data_word_t push_data_i,
    input  logic                validate_i,
    output logic                full_o,
    output csr_pkg::csr_wen_t   commit_wen_o,
    output csr_pkg::data_word_t commit_data_o
);

    localparam int PTR_W = $clog2(BUFFER_DEPTH);

    logic [PTR_W-1:0] wr_ptr, rd_ptr;
    logic [PTR_W-1:0] wr_ptr_inc, rd_ptr_inc;
    logic             full_q, empty_q;
    logic             push, pop;

    // Pending writes, enable vector kept next to its data
    csr_pkg::csr_wen_t   wen_mem  [BUFFER_DEPTH];
    csr_pkg::data_word_t data_mem [BUFFER_DEPTH];

    // Depth is a power of two so the pointers wrap on their own
    assign wr_ptr_inc = wr_ptr + 1'b1;
    assign rd_ptr_inc = rd_ptr + 1'b1;

    // A push while full is dropped
    assign push = push_i & !full_q;
    assign pop  = validate_i & !empty_q;

    // ============================================================
    // Pointers and status flags
    // ============================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr_inc;
            end
            if (pop) begin
                rd_ptr <= rd_ptr_inc;
            end

            // Simultaneous push and pop leaves the fill level alone
            case ({push, pop})
                2'b10: begin
                    empty_q <= 1'b0;
                    full_q  <= (wr_ptr_inc == rd_ptr);
                end
                2'b01: begin
                    full_q  <= 1'b0;
                    empty_q <= (rd_ptr_inc == wr_ptr);
                end
                default: ;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk_i) begin
        if (push) begin
            wen_mem[wr_ptr]  <= push_wen_i;
            data_mem[wr_ptr] <= push_data_i;
        end
    end

    // Head entry goes out only on a pop
    assign commit_wen_o  = pop ? wen_mem[rd_ptr] : '0;
    assign commit_data_o = data_mem[rd_ptr];
    assign full_o        = full_q;

    // The core must respect back-pressure
    a_no_push_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(push_i && full_q));

    // At most one register updates per commit
    a_commit_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(commit_wen_o));

endmodule : csr_write_buffer

/* flist.f */
csr_pkg.sv
csr_write_buffer.sv
csr_trap_regs.sv
csr_counters.sv
csr_access_decode.sv
csr_unit_top.sv
tb_csr_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_csr_unit -f flist.f -o sim_csr_unit

# A failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/sim_csr_unit

/* tb_csr_unit.sv */
`timescale 1ns/1ps

module tb_csr_unit;

    localparam int          CLK_PERIOD        = 100;
    localparam int          BUFFER_DEPTH      = 8;
    localparam logic [31:0] HART_ID           = 32'h0000_0003;
    localparam int          MAX_RECORDS       = 128;
    localparam int          CYCLES_PER_RECORD = 200;

    // Pattern opcodes
    localparam logic [31:0] OP_IDLE          = 32'h0;
    localparam logic [31:0] OP_WRITE         = 32'h1;
    localparam logic [31:0] OP_WRITE_RANDOM  = 32'h2;
    localparam logic [31:0] OP_VALIDATE      = 32'h3;
    localparam logic [31:0] OP_FLUSH         = 32'h4;
    localparam logic [31:0] OP_READ_CHECK    = 32'h5;
    localparam logic [31:0] OP_ILLEGAL_CHECK = 32'h6;
    localparam logic [31:0] OP_EXCEPTION     = 32'h7;
    localparam logic [31:0] OP_INTERRUPT     = 32'h8;
    localparam logic [31:0] OP_MRET          = 32'h9;
    localparam logic [31:0] OP_RETIRE        = 32'hA;
    localparam logic [31:0] OP_FULL_CHECK    = 32'hB;
    localparam logic [31:0] OP_HANDLER_CHECK = 32'hC;
    localparam logic [31:0] OP_PRIV_CHECK    = 32'hD;
    localparam logic [31:0] OP_END           = 32'hF;

    logic        clk, rst_n;
    logic        csr_write_access, csr_read_access;
    logic [11:0] csr_address;
    logic [31:0] csr_data_write, trap_instruction_pc;
    logic        csr_write_validate, flush, instruction_retired;
    logic        interrupt_request, exception, machine_return_instr;
    logic [7:0]  interrupt_vector;
    logic [4:0]  exception_vector;
    logic [31:0] csr_data_read, handler_pc;
    logic        illegal_csr_access, buffer_full, glb_int_enabled, current_privilege;

    // Four words per record: opcode, address, data, expected
    logic [31:0] pattern_mem [4*MAX_RECORDS];
    int          num_records = 0;
    logic [31:0] rng_state, rand_val, mark_value;

    csr_unit_top #(.BUFFER_DEPTH(BUFFER_DEPTH), .HART_ID(HART_ID)) i_dut (
        .clk_i(clk), .rst_n_i(rst_n),
        .csr_write_access_i(csr_write_access), .csr_read_access_i(csr_read_access),
        .csr_address_i(csr_address), .csr_data_write_i(csr_data_write),
        .csr_write_validate_i(csr_write_validate), .flush_i(flush),
        .instruction_retired_i(instruction_retired),
        .interrupt_request_i(interrupt_request), .exception_i(exception),
        .interrupt_vector_i(interrupt_vector), .exception_vector_i(exception_vector),
        .trap_instruction_pc_i(trap_instruction_pc),
        .machine_return_instr_i(machine_return_instr),
        .csr_data_read_o(csr_data_read), .illegal_csr_access_o(illegal_csr_access),
        .buffer_full_o(buffer_full), .handler_pc_o(handler_pc),
        .glb_int_enabled_o(glb_int_enabled), .current_privilege_o(current_privilege)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ============================================================
    // Helpers
    // ============================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // Every strobe back to quiet, called right after a rising edge
    task automatic drive_idle();
        csr_write_access     <= 1'b0;
        csr_read_access      <= 1'b0;
        csr_address          <= '0;
        csr_data_write       <= '0;
        csr_write_validate   <= 1'b0;
        flush                <= 1'b0;
        instruction_retired  <= 1'b0;
        interrupt_request    <= 1'b0;
        exception            <= 1'b0;
        interrupt_vector     <= '0;
        exception_vector     <= '0;
        trap_instruction_pc  <= '0;
        machine_return_instr <= 1'b0;
    endtask

    // Legal read, sampled on the falling edge
    task automatic read_csr(input logic [11:0] addr, output logic [31:0] value);
        @(posedge clk);
        drive_idle();
        csr_address     <= addr;
        csr_read_access <= 1'b1;
        @(negedge clk);
        check_value({31'b0, illegal_csr_access}, 32'h0, "legal read flagged illegal");
        value = csr_data_read;
    endtask

    // Even trap PC or scratch data from the generator
    task automatic draw_random(input logic even);
        rng_state = xorshift32(rng_state);
        rand_val  = even ? {rng_state[31:1], 1'b0} : rng_state;
    endtask

    // ============================================================
    // Record player
    // ============================================================

    task automatic run_record(input int idx);
        logic [31:0] op, data, expected, value;
        logic [11:0] addr;
        op       = pattern_mem[4*idx];
        addr     = pattern_mem[4*idx+1][11:0];
        data     = pattern_mem[4*idx+2];
        expected = pattern_mem[4*idx+3];
        if (op == OP_WRITE_RANDOM) begin
            draw_random(1'b0);
            data = rand_val;
        end else if (op == OP_EXCEPTION || op == OP_INTERRUPT) begin
            draw_random(1'b1);
        end
        case (op)
            OP_IDLE: begin
                @(posedge clk);
                drive_idle();
                repeat ((data > 1) ? data - 1 : 0) @(posedge clk);
            end
            OP_RETIRE: begin
                // One retire pulse per cycle
                repeat (data) begin
                    @(posedge clk);
                    drive_idle();
                    instruction_retired <= 1'b1;
                end
            end
            OP_READ_CHECK: begin
                read_csr(addr, value);
                case (data)
                    32'd0: begin
                        check_value(value, expected, "read data");
                        // Global enable follows the MIE bit of mstatus
                        if (addr == 12'h300) begin
                            check_value({31'b0, glb_int_enabled}, {31'b0, expected[3]},
                                        "global interrupt enable");
                        end
                    end
                    32'd1: check_value(value, rand_val, "read of random value");
                    32'd2: mark_value = value;
                    32'd3: check_value(value - mark_value, expected, "counter delta");
                    32'd4: check_value(value, HART_ID, "mhartid");
                    default: begin
                        $display("Pattern record %0d has an unknown read mode", idx);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "bad pattern");
                    end
                endcase
            end
            default: begin
                @(posedge clk);
                drive_idle();
                case (op)
                    OP_WRITE, OP_WRITE_RANDOM: begin
                        csr_address      <= addr;
                        csr_write_access <= 1'b1;
                        csr_data_write   <= data;
                    end
                    OP_VALIDATE: csr_write_validate <= 1'b1;
                    OP_FLUSH:    flush <= 1'b1;
                    OP_MRET:     machine_return_instr <= 1'b1;
                    OP_EXCEPTION: begin
                        exception           <= 1'b1;
                        exception_vector    <= data[4:0];
                        trap_instruction_pc <= rand_val;
                    end
                    OP_INTERRUPT: begin
                        interrupt_request   <= 1'b1;
                        interrupt_vector    <= data[7:0];
                        trap_instruction_pc <= rand_val;
                    end
                    OP_ILLEGAL_CHECK: begin
                        // Data column picks a write or a read access
                        csr_address      <= addr;
                        csr_write_access <= data[0];
                        csr_read_access  <= !data[0];
                        @(negedge clk);
                        check_value({31'b0, illegal_csr_access}, expected, "illegal flag");
                    end
                    OP_FULL_CHECK: begin
                        @(negedge clk);
                        check_value({31'b0, buffer_full}, expected, "buffer full flag");
                    end
                    OP_HANDLER_CHECK: begin
                        @(negedge clk);
                        check_value(handler_pc, expected, "handler PC");
                    end
                    OP_PRIV_CHECK: begin
                        @(negedge clk);
                        check_value({31'b0, current_privilege}, expected, "privilege");
                    end
                    default: begin
                        $display("Pattern record %0d has unknown opcode %h", idx, op);
                        $display("TEST RESULT: FAIL");
                        $fatal(1, "bad pattern");
                    end
                endcase
            end
        endcase
    endtask

    // Watchdog sized by the number of records
    initial begin
        wait (num_records > 0);
        repeat (num_records * CYCLES_PER_RECORD) @(posedge clk);
        $display("Timeout: the pattern run did not finish in %0d cycles",
                 num_records * CYCLES_PER_RECORD);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int count;
        rng_state  = 32'h3016;
        rand_val   = '0;
        mark_value = '0;
        rst_n      = 1'b0;
        drive_idle();
        $readmemh("csr_patterns.hex", pattern_mem);
        count = 0;
        while (count < MAX_RECORDS && !$isunknown(pattern_mem[4*count]) &&
               pattern_mem[4*count] != OP_END) begin
            count++;
        end
        if (count == 0) begin
            $display("The pattern file holds no records");
            $display("TEST RESULT: FAIL");
            $fatal(1, "no stimulus");
        end
        num_records = count;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < num_records; i++) begin
            run_record(i);
        end
        @(posedge clk);
        drive_idle();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : tb_csr_unit
